//--- design/miner_pkg.sv
// shared constants, header blocks, engine and register port structs for the miner control
`default_nettype none

package miner_pkg;

	////////////////////////////////
	// widths
	////////////////////////////////
	localparam int NONCE_W    = 32;
	localparam int OPCNT_W    = 48;   // total ops, wraps after ~68 days at 48 MHz
	localparam int DIGEST_W   = 32;   // low word of second sha, zero means hit
	localparam int RATE_W     = 32;
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;
	localparam int SCHED_W    = 7;    // holds 0..108

	// pass schedule, one request per 36 cycle engine slot
	localparam logic [SCHED_W-1:0] SCHED_LAST    = 7'd108;
	localparam logic [SCHED_W-1:0] SCHED_INIT_AT = 7'd1;
	localparam logic [SCHED_W-1:0] SCHED_HASH_AT = 7'd37;
	localparam logic [SCHED_W-1:0] SCHED_REDO_AT = 7'd73;

	// button timing in ms
	localparam int PRESS_MS   = 5;    // stable high before a press counts
	localparam int PULSE_MS   = 25;   // lockout after the press
	localparam int LONG_MS    = 667;  // hold for continuous mode
	localparam int RELEASE_MS = 100;  // low this long ends a press

	localparam int DEF_TICKS_PER_MS = 48000;
	localparam int DEF_RATE_TICKS   = 48000000;  // one second at 48 MHz

	// engine pass modes
	typedef enum logic [1:0] {
		MODE_HASH = 2'd0,  // from state, state updated
		MODE_INIT = 2'd1,  // from H0..H7
		MODE_REDO = 2'd3   // from state, result not kept
	} mode_e;

	// 80 byte block header plus sha padding, words already in engine order
	localparam logic [0:15][31:0] HDR_BLOCK0 = {
		32'h01000000, 32'h7cc5c24c, 32'h39fd0579, 32'h2c286599,
		32'h9e25fe87, 32'he066a37d, 32'h7a08dc35, 32'h1f140000,
		32'h00000000, 32'h49b62764, 32'h25052b2f, 32'hc24bfb78,
		32'h4eca5536, 32'h9b2b9e8b, 32'h4180c869, 32'h778cacb2
	};
	localparam logic [0:2][31:0] HDR_BLOCK1_PREFIX = {
		32'hbed17115, 32'h9395e64d, 32'h2194261a  // merkle tail, time, bits
	};
	localparam logic [0:11][31:0] HDR_BLOCK1_TAIL = {
		32'h80000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'h00000280  // 640 bit length
	};

	// second block as the sequencer fills it
	typedef struct packed {
		logic [0:2][31:0]  prefix;
		logic [NONCE_W-1:0] nonce;  // byte swapped
		logic [0:11][31:0] pad;
	} hdr_tail_t;

	typedef union packed {
		logic [0:15][31:0] words;  // engine view, word 0 first
		hdr_tail_t         hdr;
	} msg_block_u;

	typedef struct packed {
		logic               valid;
		mode_e              mode;
		logic [NONCE_W-1:0] nonce;  // tag, echoed back with the digest
		msg_block_u         block;
	} hash_req_t;

	typedef struct packed {
		logic                valid;
		logic [NONCE_W-1:0]  nonce;
		logic [DIGEST_W-1:0] digest;
	} hash_rsp_t;

	// axi4-lite read channels only
	typedef struct packed {
		logic                  arvalid;
		logic [AXI_ADDR_W-1:0] araddr;
		logic                  rready;
	} axil_rd_req_t;

	typedef struct packed {
		logic                  arready;
		logic                  rvalid;
		logic [AXI_DATA_W-1:0] rdata;
		logic [1:0]            rresp;
	} axil_rd_rsp_t;

	// register map
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_HIT_NONCE = 8'h04;
	localparam logic [AXI_ADDR_W-1:0] REG_OPS_LO    = 8'h08;
	localparam logic [AXI_ADDR_W-1:0] REG_OPS_HI    = 8'h0C;
	localparam logic [AXI_ADDR_W-1:0] REG_RATE      = 8'h10;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- design/button_debounce.sv
// fire button conditioning, gives a short press pulse and a long hold level to the sequencer
`default_nettype none

module button_debounce #(
	parameter int TICKS_PER_MS = miner_pkg::DEF_TICKS_PER_MS
) (
	input  logic clk,
	input  logic reset,
	input  logic i_button,
	output logic o_short,
	output logic o_long
);
	import miner_pkg::*;

	localparam int PRESS_TICKS   = PRESS_MS * TICKS_PER_MS;
	localparam int PULSE_TICKS   = PULSE_MS * TICKS_PER_MS;
	localparam int LONG_TICKS    = LONG_MS * TICKS_PER_MS;
	localparam int RELEASE_TICKS = RELEASE_MS * TICKS_PER_MS;
	localparam int HOLD_W = $clog2(LONG_TICKS + 1);
	localparam int REL_W  = $clog2(RELEASE_TICKS + 1);

	localparam logic [HOLD_W-1:0] HOLD_PRESS = HOLD_W'(PRESS_TICKS);
	localparam logic [HOLD_W-1:0] HOLD_PULSE = HOLD_W'(PULSE_TICKS);
	localparam logic [HOLD_W-1:0] HOLD_LONG  = HOLD_W'(LONG_TICKS);
	localparam logic [REL_W-1:0]  REL_DONE   = REL_W'(RELEASE_TICKS);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_PRESS,  // high, not yet stable
		S_WAIT_PULSE,  // accepted, input ignored
		S_WAIT_LONG,
		S_LONG,
		S_WAIT_OFF,    // released after short
		S_WAIT_LOFF    // released after long
	} state_e;

	logic [2:0]        sync;
	logic              btn;
	state_e            state;
	logic [HOLD_W-1:0] hold_cnt;  // time since press began
	logic [REL_W-1:0]  rel_cnt;   // time low while releasing

	assign btn = sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[1:0], i_button};  // async pin, 3 flops
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:       state <= btn ? S_WAIT_PRESS : S_IDLE;
				S_WAIT_PRESS: state <= !btn ? S_IDLE :
					(hold_cnt == HOLD_PRESS) ? S_WAIT_PULSE : S_WAIT_PRESS;
				S_WAIT_PULSE: state <= (hold_cnt == HOLD_PULSE) ? S_WAIT_LONG : S_WAIT_PULSE;
				S_WAIT_LONG:  state <= !btn ? S_WAIT_OFF :
					(hold_cnt >= HOLD_LONG) ? S_LONG : S_WAIT_LONG;
				S_LONG:       state <= !btn ? S_WAIT_LOFF : S_LONG;
				S_WAIT_OFF:   state <= btn ? S_WAIT_LONG :
					(rel_cnt == REL_DONE) ? S_IDLE : S_WAIT_OFF;
				S_WAIT_LOFF:  state <= btn ? S_LONG :
					(rel_cnt == REL_DONE) ? S_IDLE : S_WAIT_LOFF;
				default:      state <= S_IDLE;
			endcase
		end
	end

	// counters
	always_ff @(posedge clk) begin
		if (reset) begin
			hold_cnt <= '0;
			rel_cnt  <= '0;
		end else begin
			if (state == S_IDLE)
				hold_cnt <= '0;
			else if (hold_cnt != HOLD_LONG)
				hold_cnt <= hold_cnt + 1'b1;  // saturates while held
			rel_cnt <= (state == S_WAIT_OFF || state == S_WAIT_LOFF) ? rel_cnt + 1'b1 : '0;
		end
	end

	// one pulse when the press wait completes
	always_ff @(posedge clk) begin
		if (reset)
			o_short <= 1'b0;
		else
			o_short <= (state == S_WAIT_PRESS) && btn && (hold_cnt == HOLD_PRESS);
	end

	assign o_long = (state == S_LONG) || (state == S_WAIT_LOFF);  // held through release bounce

endmodule

`default_nettype wire

//--- design/job_sequencer.sv
// fixed 108 cycle job schedule, sends INIT, HASH and REDO passes with the nonce to the engine
`default_nettype none

module job_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_short,
	input  logic                 i_long,
	input  logic                 i_hit,
	output miner_pkg::hash_req_t o_req,
	output logic                 o_continuous
);
	import miner_pkg::*;

	logic               long_d;
	logic               continuous;
	logic               go;          // start or keep going
	logic [SCHED_W-1:0] sched_cnt;
	logic [NONCE_W-1:0] nonce;
	logic               is_init;
	logic               is_hash;
	logic               is_redo;
	msg_block_u         block;

	////////////////////////////////
	// continuous mode
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			long_d     <= 1'b0;
			continuous <= 1'b0;
		end else begin
			long_d <= i_long;
			if (i_long && !long_d)
				continuous <= 1'b1;  // long hold starts it, button can be let go
			else if (i_short || i_hit)
				continuous <= 1'b0;  // next press or a hit stops it
		end
	end

	assign go           = i_short || continuous;
	assign o_continuous = continuous;

	////////////////////////////////
	// schedule and nonce
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			sched_cnt <= '0;
			nonce     <= '0;
		end else begin
			if (sched_cnt == '0)
				sched_cnt <= go ? SCHED_INIT_AT : '0;
			else if (sched_cnt == SCHED_LAST)
				sched_cnt <= go ? SCHED_REDO_AT : '0;  // loop on redo, or finish last pass
			else
				sched_cnt <= sched_cnt + 1'b1;

			if (is_hash || is_redo)
				nonce <= nonce + 1'b1;  // one nonce per block 1 pass
		end
	end

	assign is_init = (sched_cnt == SCHED_INIT_AT);
	assign is_hash = (sched_cnt == SCHED_HASH_AT);
	assign is_redo = (sched_cnt == SCHED_REDO_AT);

	// block 0 whole, block 1 with nonce in little endian byte order
	always_comb begin
		if (is_init) begin
			block.words = HDR_BLOCK0;
		end else begin
			block.hdr.prefix = HDR_BLOCK1_PREFIX;
			block.hdr.nonce  = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};
			block.hdr.pad    = HDR_BLOCK1_TAIL;
		end
	end

	always_comb begin
		o_req.valid = is_init || is_hash || is_redo;
		if (is_init)
			o_req.mode = MODE_INIT;
		else if (is_redo)
			o_req.mode = MODE_REDO;
		else
			o_req.mode = MODE_HASH;
		o_req.nonce = nonce;  // tag only, not swapped
		o_req.block = block;
	end

endmodule

`default_nettype wire

//--- design/result_monitor.sv
// watches engine results for a hit, keeps the hit nonce and the total and per window op counts
`default_nettype none

module result_monitor #(
	parameter int RATE_TICKS = miner_pkg::DEF_RATE_TICKS
) (
	input  logic                                clk,
	input  logic                                reset,
	input  miner_pkg::hash_rsp_t                i_rsp,
	input  logic                                i_continuous,
	output logic                                o_hit,
	output logic                                o_hit_flag,
	output logic [miner_pkg::NONCE_W-1:0]       o_hit_nonce,
	output logic [miner_pkg::OPCNT_W-1:0]       o_op_count,
	output logic [miner_pkg::RATE_W-1:0]        o_rate
);
	import miner_pkg::*;

	localparam int TICK_W = $clog2(RATE_TICKS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(RATE_TICKS - 1);

	logic               hit_now;
	logic [NONCE_W-1:0] rsp_nonce_q;  // nonce of the response behind o_hit
	logic [TICK_W-1:0]  tick_cnt;
	logic [RATE_W-1:0]  win_cnt;      // responses so far in this window
	logic               win_end;

	assign hit_now = i_rsp.valid && (i_rsp.digest == '0);
	assign win_end = (tick_cnt == TICK_LAST);

	always_ff @(posedge clk) begin
		if (i_rsp.valid)
			rsp_nonce_q <= i_rsp.nonce;
	end

	////////////////////////////////
	// hit
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			o_hit       <= 1'b0;
			o_hit_flag  <= 1'b0;
			o_hit_nonce <= '0;
		end else begin
			o_hit <= hit_now;
			// continuous still set here, it clears a cycle after o_hit
			if (o_hit && i_continuous && !o_hit_flag) begin
				o_hit_flag  <= 1'b1;
				o_hit_nonce <= rsp_nonce_q;  // first one wins
			end
		end
	end

	////////////////////////////////
	// op counters
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			o_op_count <= '0;
			tick_cnt   <= '0;
			win_cnt    <= '0;
			o_rate     <= '0;
		end else begin
			if (i_rsp.valid)
				o_op_count <= o_op_count + 1'b1;
			tick_cnt <= win_end ? '0 : tick_cnt + 1'b1;
			if (win_end) begin
				o_rate  <= win_cnt + RATE_W'(i_rsp.valid);  // include a response on the last tick
				win_cnt <= '0;
			end else if (i_rsp.valid) begin
				win_cnt <= win_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/stats_axil_regs.sv
// read only axi4-lite slave that returns miner status, hit nonce and op statistics
`default_nettype none

module stats_axil_regs (
	input  logic                            clk,
	input  logic                            reset,
	input  miner_pkg::axil_rd_req_t         i_axil,
	output miner_pkg::axil_rd_rsp_t         o_axil,
	input  logic                            i_continuous,
	input  logic                            i_hit_flag,
	input  logic [miner_pkg::NONCE_W-1:0]   i_hit_nonce,
	input  logic [miner_pkg::OPCNT_W-1:0]   i_op_count,
	input  logic [miner_pkg::RATE_W-1:0]    i_rate
);
	import miner_pkg::*;

	logic                  rvalid;
	logic [AXI_DATA_W-1:0] rdata_q;
	logic [1:0]            rresp_q;
	logic                  accept;
	logic [AXI_DATA_W-1:0] rd_data;  // decoded, before capture
	logic [1:0]            rd_resp;

	assign accept = i_axil.arvalid && !rvalid;  // arready is !rvalid

	////////////////////////////////
	// address decode
	////////////////////////////////
	always_comb begin
		rd_resp = RESP_OKAY;
		case (i_axil.araddr)
			REG_STATUS:    rd_data = {30'b0, i_hit_flag, i_continuous};
			REG_HIT_NONCE: rd_data = i_hit_nonce;
			REG_OPS_LO:    rd_data = i_op_count[31:0];
			REG_OPS_HI:    rd_data = AXI_DATA_W'(i_op_count[OPCNT_W-1:32]);
			REG_RATE:      rd_data = i_rate;
			default: begin
				rd_data = '0;
				rd_resp = RESP_SLVERR;  // hole in the map
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			rvalid <= 1'b0;
		else if (accept)
			rvalid <= 1'b1;
		else if (i_axil.rready)
			rvalid <= 1'b0;  // only reached with rvalid high or already low
	end

	// data captured at accept, frozen while the master stalls
	always_ff @(posedge clk) begin
		if (accept) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	always_comb begin
		o_axil.arready = !rvalid;  // one read outstanding
		o_axil.rvalid  = rvalid;
		o_axil.rdata   = rdata_q;
		o_axil.rresp   = rresp_q;
	end

endmodule

`default_nettype wire

//--- design/sha_miner_ctrl.sv
// miner control top, button in, hash requests out, engine results in, stats over axi4-lite
`default_nettype none

module sha_miner_ctrl #(
	parameter int TICKS_PER_MS = miner_pkg::DEF_TICKS_PER_MS,
	parameter int RATE_TICKS   = miner_pkg::DEF_RATE_TICKS
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_fire_button,
	output miner_pkg::hash_req_t    o_req,
	input  miner_pkg::hash_rsp_t    i_rsp,
	input  miner_pkg::axil_rd_req_t i_axil,
	output miner_pkg::axil_rd_rsp_t o_axil
);
	import miner_pkg::*;

	logic               short_press;
	logic               long_press;
	logic               hit;         // one cycle, zero digest
	logic               continuous;
	logic               hit_flag;
	logic [NONCE_W-1:0] hit_nonce;
	logic [OPCNT_W-1:0] op_count;
	logic [RATE_W-1:0]  rate;

	// input side
	button_debounce #(
		.TICKS_PER_MS (TICKS_PER_MS)
	) u_button_debounce (
		.clk      (clk),
		.reset    (reset),
		.i_button (i_fire_button),
		.o_short  (short_press),
		.o_long   (long_press)
	);

	// processing
	job_sequencer u_job_sequencer (
		.clk          (clk),
		.reset        (reset),
		.i_short      (short_press),
		.i_long       (long_press),
		.i_hit        (hit),
		.o_req        (o_req),
		.o_continuous (continuous)
	);

	// output side
	result_monitor #(
		.RATE_TICKS (RATE_TICKS)
	) u_result_monitor (
		.clk          (clk),
		.reset        (reset),
		.i_rsp        (i_rsp),
		.i_continuous (continuous),
		.o_hit        (hit),
		.o_hit_flag   (hit_flag),
		.o_hit_nonce  (hit_nonce),
		.o_op_count   (op_count),
		.o_rate       (rate)
	);

	stats_axil_regs u_stats_axil_regs (
		.clk          (clk),
		.reset        (reset),
		.i_axil       (i_axil),
		.o_axil       (o_axil),
		.i_continuous (continuous),
		.i_hit_flag   (hit_flag),
		.i_hit_nonce  (hit_nonce),
		.i_op_count   (op_count),
		.i_rate       (rate)
	);

endmodule

`default_nettype wire

//--- test/sha_miner_props.sv
// protocol checks bound into the miner control top, request spacing and axi read channel rules
`default_nettype none

module sha_miner_props (
	input logic                    clk,
	input logic                    reset,
	input miner_pkg::hash_req_t    i_req,
	input miner_pkg::axil_rd_req_t i_axil,
	input miner_pkg::axil_rd_rsp_t i_axil_rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [6:0] since_req;  // cycles since the last request, saturates

	always_ff @(posedge clk) begin
		if (reset)
			since_req <= 7'h7f;
		else if (i_req.valid)
			since_req <= '0;
		else if (since_req != 7'h7f)
			since_req <= since_req + 1'b1;
	end

	////////////////////////////////
	// request channel
	////////////////////////////////
	// engine takes one pass per 36 cycle slot
	a_req_gap: assert property (@(posedge clk) disable iff (reset)
		i_req.valid |-> since_req >= 7'd35)
		else $error("hash requests closer than one engine slot");

	////////////////////////////////
	// axi read channel
	////////////////////////////////
	a_rd_hold: assert property (@(posedge clk) disable iff (reset)
		i_axil_rsp.rvalid && !i_axil.rready |=>
		i_axil_rsp.rvalid && $stable(i_axil_rsp.rdata) && $stable(i_axil_rsp.rresp))
		else $error("read data changed while the master stalled");

	a_rd_after_accept: assert property (@(posedge clk) disable iff (reset)
		i_axil.arvalid && i_axil_rsp.arready |=> i_axil_rsp.rvalid)
		else $error("no read data one cycle after address accept");

endmodule

bind sha_miner_ctrl sha_miner_props u_sha_miner_props (
	.clk        (clk),
	.reset      (reset),
	.i_req      (o_req),
	.i_axil     (i_axil),
	.i_axil_rsp (o_axil)
);

`default_nettype wire

//--- test/tb_sha_miner_ctrl.sv
// testbench for the miner control top, models the hash engine and reads results over axi4-lite
`default_nettype none

module tb_sha_miner_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import miner_pkg::*;

	localparam int TICKS_PER_MS = 8;
	localparam int RATE_TICKS   = 2000;
	localparam int ENGINE_LAT   = 20;    // cycles from block 1 request to result
	localparam int RD_LIMIT     = 20;    // cycles for one axi read
	localparam int POLL_LIMIT   = 100;   // status polls

	logic         clk = 1'b0;
	logic         reset = 1'b1;
	logic         fire = 1'b0;
	hash_req_t    req;
	hash_rsp_t    rsp_drv = '0;
	axil_rd_req_t axil_req = '0;
	axil_rd_rsp_t axil_rsp;

	integer             seed = 32;
	int                 cyc = 0;
	int                 errors = 0;
	int                 tests = 0;
	int                 test_base = 0;
	bit                 hits_on = 1'b1;     // engine model returns zero digests
	hash_req_t          req_log[$];
	int                 req_cyc[$];
	int                 pend_due[$];        // engine model pipeline
	logic [31:0]        pend_nonce[$];
	logic [OPCNT_W-1:0] rsp_cnt = '0;
	logic [31:0]        win = '0;
	logic [31:0]        rate_exp = '0;      // responses in the last full window
	int                 tick = 0;
	logic [OPCNT_W-1:0] ops_snap;           // expected values at read drive time
	logic [31:0]        rate_snap;

	sha_miner_ctrl #(
		.TICKS_PER_MS (TICKS_PER_MS),
		.RATE_TICKS   (RATE_TICKS)
	) u_sha_miner_ctrl (
		.clk           (clk),
		.reset         (reset),
		.i_fire_button (fire),
		.o_req         (req),
		.i_rsp         (rsp_drv),
		.i_axil        (axil_req),
		.o_axil        (axil_rsp)
	);

	always #2 clk = ~clk;  // 4 ns

	////////////////////////////////
	// engine model and bookkeeping
	////////////////////////////////
	// sampled mid cycle where dut outputs are settled
	always @(negedge clk) begin
		cyc++;
		if (reset) begin
			tick     = 0;
			win      = '0;
			rate_exp = '0;
			rsp_cnt  = '0;
		end else begin
			if (req.valid) begin
				req_log.push_back(req);
				req_cyc.push_back(cyc);
				if (req.mode != MODE_INIT) begin  // only block 1 passes give a result
					pend_due.push_back(cyc + ENGINE_LAT);
					pend_nonce.push_back(req.nonce);
				end
			end
			if (rsp_drv.valid)
				rsp_cnt = rsp_cnt + 1'b1;
			if (tick == RATE_TICKS - 1) begin
				rate_exp = rsp_drv.valid ? win + 32'd1 : win;  // window closes
				win      = '0;
				tick     = 0;
			end else begin
				if (rsp_drv.valid)
					win = win + 32'd1;
				tick++;
			end
		end
	end

	function automatic logic [31:0] nonzero_digest();
		logic [31:0] d;
		d = $random(seed);
		if (d == '0)
			d = 32'd1;
		return d;
	endfunction

	always @(posedge clk) begin
		#1;
		rsp_drv = '0;
		if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
			void'(pend_due.pop_front());
			rsp_drv.valid  = 1'b1;
			rsp_drv.nonce  = pend_nonce.pop_front();
			rsp_drv.digest = (hits_on && rsp_drv.nonce % 32'd7 == 32'd5) ? '0 : nonzero_digest();
		end
	end

	////////////////////////////////
	// helpers
	////////////////////////////////
	function automatic logic [0:15][31:0] block1_for(input logic [31:0] n);
		logic [31:0] swapped;
		swapped = {<<8{n}};  // header nonce is little endian
		return {HDR_BLOCK1_PREFIX, swapped, HDR_BLOCK1_TAIL};
	endfunction

	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("error %0t: %s", $time, what);
		end
	endtask

	task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("error %0t: %s read %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic press_button(input int hold);
		fire = 1'b1;
		idle(hold);
		fire = 1'b0;
	endtask

	task automatic start_test();
		test_base = errors;
		req_log.delete();
		req_cyc.delete();
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == test_base) ? "ok" : "failed");
	endtask

	// one read, rready held low for stall cycles
	task automatic axi_read(input logic [7:0] addr, input int stall,
			output logic [31:0] data, output logic [1:0] resp);
		int t;
		t = 0;
		ops_snap  = rsp_cnt;
		rate_snap = rate_exp;
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		axil_req.rready  = 1'b0;
		idle(1);
		while (!axil_rsp.rvalid) begin
			if (t >= RD_LIMIT)
				report_timeout("axi read data");
			idle(1);
			t++;
		end
		axil_req.arvalid = 1'b0;
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		repeat (stall) begin
			idle(1);
			expect_true(axil_rsp.rvalid && axil_rsp.rdata == data && axil_rsp.rresp == resp,
				"read response moved under back-pressure");
		end
		axil_req.rready = 1'b1;
		idle(1);
		axil_req.rready = 1'b0;
		expect_true(!axil_rsp.rvalid, "rvalid still high after rready");
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] d;
		logic [1:0]  r;
		axi_read(addr, 0, d, r);
		expect_word(d, exp, what);
		expect_true(r == RESP_OKAY, "mapped register gave an error response");
	endtask

	task automatic wait_status(input int bit_idx, input logic value, input string what);
		logic [31:0] d;
		logic [1:0]  r;
		int          t;
		t = 0;
		axi_read(REG_STATUS, 0, d, r);
		while (d[bit_idx] !== value) begin
			if (t >= POLL_LIMIT)
				report_timeout(what);
			idle(10);
			axi_read(REG_STATUS, 0, d, r);
			t++;
		end
	endtask

	task automatic wait_reqs(input int n, input int limit);
		int t;
		t = 0;
		while (req_log.size() < n) begin
			if (t >= limit)
				report_timeout("hash requests");
			idle(1);
			t++;
		end
	endtask

	// after the schedule drains nothing more may be issued
	task automatic expect_quiet();
		int n;
		idle(150);
		n = req_log.size();
		idle(300);
		expect_true(req_log.size() == n, "requests still issued after stop");
	endtask

	////////////////////////////////
	// tests
	////////////////////////////////
	initial begin
		logic [31:0] d;
		logic [1:0]  r;
		int          k;
		int          pairs;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;

		// after reset
		start_test();
		expect_true(!req.valid, "request valid after reset");
		expect_true(!axil_rsp.rvalid && axil_rsp.arready, "read channel not idle after reset");
		read_expect(REG_STATUS, 32'd0, "STATUS");
		read_expect(REG_OPS_LO, 32'd0, "OPS_LO");
		read_expect(REG_OPS_HI, 32'd0, "OPS_HI");
		read_expect(REG_RATE, 32'd0, "RATE");
		finish_test("reset values");

		// short press, one job of three passes
		start_test();
		press_button(60);
		wait_reqs(3, 400);
		idle(200);
		expect_true(req_log.size() == 3, "short press did not give exactly three requests");
		expect_true(req_log[0].mode == MODE_INIT, "first pass not INIT");
		expect_true(req_log[1].mode == MODE_HASH, "second pass not HASH");
		expect_true(req_log[2].mode == MODE_REDO, "third pass not REDO");
		expect_true(req_cyc[1] - req_cyc[0] == 36 && req_cyc[2] - req_cyc[1] == 36,
			"passes not 36 cycles apart");
		expect_word(req_log[1].nonce, 32'd0, "HASH nonce");
		expect_word(req_log[2].nonce, 32'd1, "REDO nonce");
		expect_true(req_log[0].block.words == HDR_BLOCK0, "block 0 mismatch");
		expect_true(req_log[1].block.words == block1_for(32'd0), "HASH block 1 mismatch");
		expect_true(req_log[2].block.words == block1_for(32'd1), "REDO block 1 mismatch");
		idle(900);  // release settles
		finish_test("short press");

		// long press runs until nonce 5 hits
		start_test();
		press_button(5500);
		wait_status(1, 1'b1, "hit flag");
		axi_read(REG_STATUS, 0, d, r);
		expect_true(d[0] == 1'b0, "continuous mode still set after hit");
		read_expect(REG_HIT_NONCE, 32'd5, "HIT_NONCE");
		k = 2;
		foreach (req_log[i]) begin
			if (req_log[i].mode != MODE_INIT) begin
				expect_word(req_log[i].nonce, 32'(k), "block 1 nonce sequence");
				k++;
			end
		end
		expect_quiet();
		idle(900);
		finish_test("long press hit");

		// axi error and back-pressure
		start_test();
		axi_read(8'h20, 0, d, r);
		expect_word(d, 32'd0, "unmapped data");
		expect_true(r == RESP_SLVERR, "unmapped address not SLVERR");
		axi_read(REG_HIT_NONCE, 6, d, r);
		expect_word(d, 32'd5, "stalled HIT_NONCE");
		finish_test("axi behavior");

		// continuous run stopped by a short press
		start_test();
		hits_on = 1'b0;
		press_button(5500);
		wait_status(0, 1'b1, "continuous mode");
		idle(900);
		press_button(60);
		idle(150);
		axi_read(REG_STATUS, 0, d, r);
		expect_true(d[0] == 1'b0, "short press left continuous mode set");
		read_expect(REG_HIT_NONCE, 32'd5, "HIT_NONCE after stop");
		expect_quiet();
		pairs = 0;
		for (int i = 1; i < req_log.size(); i++) begin
			if (req_log[i].mode == MODE_REDO && req_log[i-1].mode == MODE_REDO &&
					req_log[i].nonce == req_log[i-1].nonce + 32'd1) begin
				expect_true(req_cyc[i] - req_cyc[i-1] == 36, "REDO repeat not 36 cycles");
				pairs++;
			end
		end
		expect_true(pairs >= 10, "too few repeated REDO passes");
		hits_on = 1'b1;
		idle(900);
		finish_test("continuous stop");

		// counters against the model's own tally
		start_test();
		expect_true(rsp_cnt != '0, "engine model sent no responses");
		axi_read(REG_OPS_LO, 0, d, r);
		expect_word(d, ops_snap[31:0], "OPS_LO");
		axi_read(REG_OPS_HI, 0, d, r);
		expect_word(d, 32'(ops_snap[47:32]), "OPS_HI");
		axi_read(REG_RATE, 0, d, r);
		expect_word(d, rate_snap, "RATE");
		finish_test("counters");

		$display("%0d tests run, %0d checks failed", tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
design/miner_pkg.sv
design/button_debounce.sv
design/job_sequencer.sv
design/result_monitor.sv
design/stats_axil_regs.sv
design/sha_miner_ctrl.sv
test/sha_miner_props.sv
test/tb_sha_miner_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = tb_sha_miner_ctrl
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
